// File: bench/mshr_checker.sv
`timescale 1ns/1ps
`include "mshr_cfg.svh"

module mshr_checker (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic [`MSHR_MISS_PORTS-1:0]                   miss_en,
  input  logic [`MSHR_MISS_PORTS-1:0][`MSHR_ADDR_W-1:0] miss_addr,
  input  logic [`MSHR_MISS_PORTS-1:0][`MSHR_DATA_W-1:0] miss_data,
  input  mshr_pkg::bus_command_e [`MSHR_MISS_PORTS-1:0] miss_command,
  input  logic                                          stored_mem_wr,
  input  logic                                          alloc_ready,
  input  logic                                          mshr_empty,
  input  logic                                          mem_wr,
  input  logic [`MSHR_ADDR_W-1:0]                       mem_addr,
  input  logic [`MSHR_DATA_W-1:0]                       mem_data,
  input  logic                                          mem_dirty,
  input  mshr_pkg::bus_command_e                        proc2mem_command,
  input  logic [`MSHR_ADDR_W-1:0]                       proc2mem_addr,
  input  logic [`MSHR_DATA_W-1:0]                       proc2mem_data,
  input  logic [`MSHR_TAG_W-1:0]                        mem2proc_response,
  input  logic                                          hold_wb,
  input  logic                                          drained,
  input  int                                            expected_loads,
  input  int                                            expected_stores,
  output int                                            error_count,
  output logic                                          report_done
);

  import mshr_pkg::*;

  localparam logic [`MSHR_DATA_W-1:0] FILL_MASK = 64'h5a5a_0000_0000_a5a5;

  // requests expected at memory, allocation order
  logic [`MSHR_ADDR_W-1:0] req_addr [$];
  bus_command_e            req_command [$];
  logic [`MSHR_DATA_W-1:0] req_data [$];
  // loads expected on the writeback port
  logic [`MSHR_ADDR_W-1:0] wb_addr [$];

  int   errors = 0;
  int   checks = 0;
  int   loads_written = 0;
  int   stores_issued = 0;
  int   reset_edges = 0;
  logic saw_full = 1'b0;
  logic finished = 1'b0;

  assign error_count = errors;
  assign report_done = finished;

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic fail_check(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic final_report();
    if (req_addr.size() != 0) fail_check("some allocated entries never reached memory");
    if (wb_addr.size() != 0) fail_check("some loads were never written back to the cache");
    compare("loads written back", 64'(loads_written), 64'(expected_loads));
    compare("stores issued", 64'(stores_issued), 64'(expected_stores));
    if (!saw_full) fail_check("alloc_ready never fell while writebacks were held off");
    $display("checker: %0d checks, %0d errors, %0d loads written back, %0d stores issued",
             checks, errors, loads_written, stores_issued);
    finished <= 1'b1;
  endtask

  always @(posedge clock) begin
    if (reset) begin
      // first edge only clears the state
      if (reset_edges > 0) begin
        compare("proc2mem_command", 64'(proc2mem_command), 64'(bus_none));
        compare("mem_wr", 64'(mem_wr), 64'd0);
        compare("mshr_empty", 64'(mshr_empty), 64'd1);
        compare("alloc_ready", 64'(alloc_ready), 64'd1);
      end
      reset_edges++;
    end else begin
      // an empty MSHR owes nothing to memory or to the cache
      if (mshr_empty && (req_addr.size() != 0 || wb_addr.size() != 0)) begin
        fail_check("mshr_empty high while allocated entries are still outstanding");
      end
      // lowest active port allocates first
      for (int p = 0; p < `MSHR_MISS_PORTS; p++) begin
        if (miss_en[p]) begin
          req_addr.push_back(miss_addr[p]);
          req_command.push_back(miss_command[p]);
          req_data.push_back(miss_data[p]);
          if (miss_command[p] == bus_load) wb_addr.push_back(miss_addr[p]);
        end
      end
      if (proc2mem_command != bus_none && mem2proc_response != '0) begin
        if (req_addr.size() == 0) begin
          fail_check("memory accepted a request while no entry was expected");
        end else begin
          compare("proc2mem_addr", 64'(proc2mem_addr), 64'(req_addr[0]));
          compare("proc2mem_command", 64'(proc2mem_command), 64'(req_command[0]));
          if (req_command[0] == bus_store) begin
            compare("proc2mem_data", proc2mem_data, req_data[0]);
            stores_issued++;
          end
          void'(req_addr.pop_front());
          void'(req_command.pop_front());
          void'(req_data.pop_front());
        end
      end
      if (mem_wr) begin
        if (wb_addr.size() == 0) begin
          fail_check("mem_wr raised while no load was waiting for writeback");
        end else begin
          compare("mem_addr", 64'(mem_addr), 64'(wb_addr[0]));
          compare("mem_data", mem_data, {32'h0, wb_addr[0]} ^ FILL_MASK);
          compare("mem_dirty", 64'(mem_dirty), 64'd0);
          if (stored_mem_wr) begin
            void'(wb_addr.pop_front());
            loads_written++;
          end
        end
      end
      if (mshr_empty && !alloc_ready) fail_check("alloc_ready low with an empty MSHR");
      if (hold_wb && !alloc_ready) saw_full = 1'b1;
      if (drained && !finished) final_report();
    end
  end

endmodule

// File: bench/tb_mshr_top.sv
`timescale 1ns/1ps
`include "mshr_cfg.svh"

module tb_mshr_top;

  import mshr_pkg::*;

  localparam int ROWS = 12;
  // writebacks held off from this row until the queue backs up
  localparam int HOLD_ROW = 4;
  localparam logic [`MSHR_DATA_W-1:0] FILL_MASK = 64'h5a5a_0000_0000_a5a5;

  // stimulus table, one row per cycle of misses
  // en is the active ports, store marks stores, addr is port 0, ports step by 'h40
  localparam logic [2:0] ROW_EN [ROWS] = '{3'b001, 3'b011, 3'b111, 3'b100, 3'b111, 3'b111,
                                           3'b111, 3'b101, 3'b010, 3'b111, 3'b110, 3'b111};
  localparam logic [2:0] ROW_STORE [ROWS] = '{3'b000, 3'b010, 3'b101, 3'b100, 3'b000, 3'b010,
                                              3'b100, 3'b001, 3'b000, 3'b111, 3'b010, 3'b001};
  localparam logic [2:0] ROW_DIRTY [ROWS] = '{3'b001, 3'b111, 3'b010, 3'b100, 3'b101, 3'b011,
                                              3'b110, 3'b101, 3'b010, 3'b000, 3'b101, 3'b110};
  localparam logic [31:0] ROW_ADDR [ROWS] = '{
    32'h1000_0000, 32'h1000_0100, 32'h1000_0200, 32'h2000_0300, 32'h2000_0400, 32'h2000_0500,
    32'h3000_0600, 32'h3000_0700, 32'h3000_0800, 32'h4000_0900, 32'h4000_0a00, 32'h4000_0b00};
  localparam logic [31:0] ROW_DATA [ROWS] = '{
    32'hc0de_0000, 32'hc0de_1111, 32'hbeef_0202, 32'hbeef_0303, 32'hfeed_0404, 32'hfeed_0505,
    32'h0bad_0606, 32'h0bad_0707, 32'h1234_0808, 32'h5678_0909, 32'h9abc_0a0a, 32'hdef0_0b0b};

  logic                                          clock = 1'b0;
  logic                                          reset = 1'b1;
  logic [`MSHR_MISS_PORTS-1:0]                   miss_en;
  logic [`MSHR_MISS_PORTS-1:0][`MSHR_ADDR_W-1:0] miss_addr;
  logic [`MSHR_MISS_PORTS-1:0][`MSHR_DATA_W-1:0] miss_data;
  bus_command_e [`MSHR_MISS_PORTS-1:0]           miss_command;
  logic [`MSHR_MISS_PORTS-1:0]                   miss_dirty;
  logic                                          stored_mem_wr = 1'b0;
  logic [`MSHR_TAG_W-1:0]                        mem2proc_response = '0;
  logic [`MSHR_TAG_W-1:0]                        mem2proc_tag = '0;
  logic [`MSHR_DATA_W-1:0]                       mem2proc_data = '0;
  logic                                          alloc_ready;
  logic                                          mshr_empty;
  logic                                          mem_wr;
  logic [`MSHR_ADDR_W-1:0]                       mem_addr;
  logic [`MSHR_DATA_W-1:0]                       mem_data;
  logic                                          mem_dirty;
  bus_command_e                                  proc2mem_command;
  logic [`MSHR_ADDR_W-1:0]                       proc2mem_addr;
  logic [`MSHR_DATA_W-1:0]                       proc2mem_data;

  logic hold_wb = 1'b0;
  logic drained = 1'b0;
  int   expected_loads = 0;
  int   expected_stores = 0;
  int   error_count;
  logic report_done;

  // memory model state
  logic [31:0]            lfsr_state = 32'h81e3_6a80;
  logic [`MSHR_TAG_W-1:0] next_tag = 4'd1;
  int                     accept_wait = -1;
  int                     ack_wait = -1;
  logic [`MSHR_TAG_W-1:0] pend_tag [$];
  logic [31:0]            pend_addr [$];
  int                     pend_wait [$];

  mshr_top mshr_top_inst (.*);

  mshr_checker mshr_checker_inst (.*);

  always #50 clock = ~clock;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic int draw_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) v = (v << 1) | int'(lfsr_step());
    return v;
  endfunction

  function automatic logic tag_busy(input logic [`MSHR_TAG_W-1:0] t);
    foreach (pend_tag[i]) begin
      if (pend_tag[i] == t) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic apply_row(input int r);
    for (int p = 0; p < `MSHR_MISS_PORTS; p++) begin
      miss_addr[p] = ROW_ADDR[r] + 32'(p * 'h40);
      miss_data[p] = {ROW_DATA[r], 32'(p)};
      miss_command[p] = ROW_STORE[r][p] ? bus_store : bus_load;
    end
    miss_dirty = ROW_DIRTY[r];
    miss_en = ROW_EN[r];
  endtask

  // memory responder and cache acknowledge share the one random stream
  always @(negedge clock) begin
    int hit;
    hit = -1;
    mem2proc_response = '0;
    mem2proc_tag = '0;
    mem2proc_data = '0;
    stored_mem_wr = 1'b0;
    if (!reset) begin
      // one completion per cycle, earliest due first
      for (int i = 0; i < pend_wait.size(); i++) begin
        if (pend_wait[i] > 0) pend_wait[i] = pend_wait[i] - 1;
        if (pend_wait[i] == 0 && hit < 0) hit = i;
      end
      if (hit >= 0) begin
        mem2proc_tag = pend_tag[hit];
        mem2proc_data = {32'h0, pend_addr[hit]} ^ FILL_MASK;
        pend_tag.delete(hit);
        pend_addr.delete(hit);
        pend_wait.delete(hit);
      end
      if (proc2mem_command != bus_none) begin
        if (accept_wait < 0) accept_wait = draw_bits(2);
        if (accept_wait > 0) begin
          accept_wait = accept_wait - 1;
        end else if (!tag_busy(next_tag)) begin
          mem2proc_response = next_tag;
          pend_tag.push_back(next_tag);
          pend_addr.push_back(proc2mem_addr);
          pend_wait.push_back(1 + draw_bits(3) % 7);
          next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
          accept_wait = -1;
        end
      end
      if (mem_wr && !hold_wb) begin
        if (ack_wait < 0) ack_wait = draw_bits(2) % 3;
        if (ack_wait == 0) begin
          stored_mem_wr = 1'b1;
          ack_wait = -1;
        end else begin
          ack_wait = ack_wait - 1;
        end
      end
    end
  end

  initial begin
    int waited;
    miss_en = '0;
    miss_addr = '0;
    miss_data = '0;
    miss_dirty = '0;
    for (int p = 0; p < `MSHR_MISS_PORTS; p++) miss_command[p] = bus_none;
    for (int r = 0; r < ROWS; r++) begin
      for (int p = 0; p < `MSHR_MISS_PORTS; p++) begin
        if (ROW_EN[r][p] && ROW_STORE[r][p]) expected_stores++;
        if (ROW_EN[r][p] && !ROW_STORE[r][p]) expected_loads++;
      end
    end
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset <= 1'b0;
    for (int r = 0; r < ROWS; r++) begin
      @(negedge clock);
      if (r == HOLD_ROW) hold_wb <= 1'b1;
      waited = 0;
      while (!alloc_ready) begin
        miss_en = '0;
        waited++;
        // queue has backed up, let the cache drain it
        if (waited >= 4) hold_wb <= 1'b0;
        @(negedge clock);
      end
      apply_row(r);
    end
    @(negedge clock);
    miss_en = '0;
    hold_wb <= 1'b0;
    while (!mshr_empty) @(negedge clock);
    drained <= 1'b1;
    wait (report_done);
    @(negedge clock);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog, about 40 cycles per table row
  initial begin
    repeat (ROWS * 40) @(posedge clock);
    $display("run timed out after %0d cycles before the MSHR drained", ROWS * 40);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: mshr.f
+incdir+src
src/mshr_pkg.sv
src/miss_intake.sv
src/mshr_queue.sv
src/mem_scheduler.sv
src/mshr_top.sv
bench/mshr_checker.sv
bench/tb_mshr_top.sv

// File: run.sh
#!/bin/sh
# build and run the MSHR testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f mshr.f --top-module tb_mshr_top \
  --Mdir obj_dir -o sim_mshr
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_mshr)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "^All tests passed$"; then
  exit 0
fi
exit 1

// File: src/mem_scheduler.sv
`timescale 1ns/1ps
`include "mshr_cfg.svh"

module mem_scheduler (
  input  logic                                                  clock,
  input  logic                                                  reset,
  input  logic                                                  issue_valid,
  input  logic                                                  issue_complete,
  input  mshr_pkg::bus_command_e                                issue_command,
  input  logic [`MSHR_ADDR_W-1:0]                               issue_addr,
  input  logic [`MSHR_DATA_W-1:0]                               issue_data,
  input  logic                                                  retire_valid,
  input  logic                                                  retire_complete,
  input  mshr_pkg::bus_command_e                                retire_command,
  input  logic [`MSHR_ADDR_W-1:0]                               retire_addr,
  input  logic [`MSHR_DATA_W-1:0]                               retire_data,
  input  logic                                                  retire_dirty,
  input  logic [`MSHR_TAG_W-1:0]                                mem2proc_response,
  input  logic                                                  stored_mem_wr,
  output mshr_pkg::bus_command_e                                proc2mem_command,
  output logic [`MSHR_ADDR_W-1:0]                               proc2mem_addr,
  output logic [`MSHR_DATA_W-1:0]                               proc2mem_data,
  output logic                                                  issue_accept,
  output logic [$clog2(`MSHR_DEPTH)-1:0]                        issue_index,
  output logic [`MSHR_TAG_W-1:0]                                issue_tag,
  output logic                                                  retire,
  output logic [$clog2(`MSHR_DEPTH)-1:0]                        retire_index,
  output logic                                                  mem_wr,
  output logic [`MSHR_ADDR_W-1:0]                               mem_addr,
  output logic [`MSHR_DATA_W-1:0]                               mem_data,
  output logic                                                  mem_dirty
);

  import mshr_pkg::*;

  localparam int IDX_W = $clog2(`MSHR_DEPTH);

  // request only while the head entry still needs memory
  assign proc2mem_command = (issue_valid && !issue_complete) ? issue_command : bus_none;
  assign proc2mem_addr    = issue_addr;
  assign proc2mem_data    = issue_data;

  // nonzero response is the accept
  assign issue_accept = (proc2mem_command != bus_none) && (mem2proc_response != '0);
  assign issue_tag    = mem2proc_response;

  // writeback head offers finished loads to the cache
  assign mem_wr    = retire_valid && retire_complete && (retire_command == bus_load);
  assign mem_addr  = retire_addr;
  assign mem_data  = retire_data;
  assign mem_dirty = retire_dirty;

  // stores leave without a cache handshake
  assign retire = retire_valid && retire_complete &&
                  ((retire_command == bus_store) || (mem_wr && stored_mem_wr));

  // issue head and writeback head
  always_ff @(posedge clock) begin
    if (reset) begin
      issue_index <= '0;
      retire_index <= '0;
    end else begin
      if (issue_accept) begin
        issue_index <= issue_index + IDX_W'(1);
      end
      if (retire) begin
        retire_index <= retire_index + IDX_W'(1);
      end
    end
  end

  // cache acknowledge only against an offered writeback
  ack_without_offer: assert property (
    @(posedge clock) disable iff (reset)
    stored_mem_wr |-> mem_wr
  ) else $error("stored_mem_wr while mem_wr is low");

endmodule

// File: src/miss_intake.sv
`timescale 1ns/1ps
`include "mshr_cfg.svh"

module miss_intake (
  input  logic                                                  clock,
  input  logic                                                  reset,
  input  logic [`MSHR_MISS_PORTS-1:0]                           miss_en,
  input  logic [`MSHR_MISS_PORTS-1:0][`MSHR_ADDR_W-1:0]         miss_addr,
  input  logic [`MSHR_MISS_PORTS-1:0][`MSHR_DATA_W-1:0]         miss_data,
  input  mshr_pkg::bus_command_e [`MSHR_MISS_PORTS-1:0]         miss_command,
  input  logic [`MSHR_MISS_PORTS-1:0]                           miss_dirty,
  input  logic                                                  alloc_ready,
  output logic [`MSHR_MISS_PORTS-1:0]                           slot_we,
  output logic [`MSHR_MISS_PORTS-1:0][`MSHR_ADDR_W-1:0]         slot_addr,
  output logic [`MSHR_MISS_PORTS-1:0][`MSHR_DATA_W-1:0]         slot_data,
  output mshr_pkg::bus_command_e [`MSHR_MISS_PORTS-1:0]         slot_command,
  output logic [`MSHR_MISS_PORTS-1:0]                           slot_dirty,
  output logic [$clog2(`MSHR_MISS_PORTS+1)-1:0]                 alloc_count
);

  import mshr_pkg::*;

  localparam int CNT_W = $clog2(`MSHR_MISS_PORTS + 1);

  // pack active ports toward offset 0, lowest port first
  always_comb begin
    logic [CNT_W-1:0] n;
    n = '0;
    slot_we = '0;
    slot_addr = '0;
    slot_data = '0;
    slot_dirty = '0;
    for (int k = 0; k < `MSHR_MISS_PORTS; k++) begin
      slot_command[k] = bus_none;
    end
    for (int p = 0; p < `MSHR_MISS_PORTS; p++) begin
      if (miss_en[p]) begin
        slot_we[n] = 1'b1;
        slot_addr[n] = miss_addr[p];
        slot_data[n] = miss_data[p];
        slot_command[n] = miss_command[p];
        slot_dirty[n] = miss_dirty[p];
        n = n + CNT_W'(1);
      end
    end
    // tail advance for the queue
    alloc_count = n;
  end

  // cache may only present misses while three slots are free
  miss_while_full: assert property (
    @(posedge clock) disable iff (reset)
    (|miss_en) |-> alloc_ready
  ) else $error("miss presented while alloc_ready is low");

endmodule

// File: src/mshr_cfg.svh
`ifndef MSHR_CFG_SVH
`define MSHR_CFG_SVH

// number of entries, power of two
`define MSHR_DEPTH 8

// miss ports per cycle
// the free-space check looks this many slots ahead of the tail
`define MSHR_MISS_PORTS 3

// address width
`define MSHR_ADDR_W 32

// one line word
`define MSHR_DATA_W 64

// memory tag, zero means no response
`define MSHR_TAG_W 4

`endif

// File: src/mshr_pkg.sv
package mshr_pkg;

  // memory bus command
  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } bus_command_e;

  // entry life cycle
  // waiting     allocated, not yet accepted by memory
  // in_progress accepted, tag recorded
  // done        memory returned the tag
  typedef enum logic [1:0] {
    waiting     = 2'd0,
    in_progress = 2'd1,
    done        = 2'd2
  } entry_state_e;

endpackage

// File: src/mshr_queue.sv
`timescale 1ns/1ps
`include "mshr_cfg.svh"

module mshr_queue (
  input  logic                                                  clock,
  input  logic                                                  reset,
  input  logic [$clog2(`MSHR_MISS_PORTS+1)-1:0]                 alloc_count,
  input  logic [`MSHR_MISS_PORTS-1:0]                           slot_we,
  input  logic [`MSHR_MISS_PORTS-1:0][`MSHR_ADDR_W-1:0]         slot_addr,
  input  logic [`MSHR_MISS_PORTS-1:0][`MSHR_DATA_W-1:0]         slot_data,
  input  mshr_pkg::bus_command_e [`MSHR_MISS_PORTS-1:0]         slot_command,
  input  logic [`MSHR_MISS_PORTS-1:0]                           slot_dirty,
  input  logic                                                  issue_accept,
  input  logic [$clog2(`MSHR_DEPTH)-1:0]                        issue_index,
  input  logic [`MSHR_TAG_W-1:0]                                issue_tag,
  input  logic                                                  retire,
  input  logic [$clog2(`MSHR_DEPTH)-1:0]                        retire_index,
  input  logic [`MSHR_TAG_W-1:0]                                mem2proc_tag,
  input  logic [`MSHR_DATA_W-1:0]                               mem2proc_data,
  output logic                                                  alloc_ready,
  output logic                                                  mshr_empty,
  output logic                                                  issue_valid,
  output logic                                                  issue_complete,
  output mshr_pkg::bus_command_e                                issue_command,
  output logic [`MSHR_ADDR_W-1:0]                               issue_addr,
  output logic [`MSHR_DATA_W-1:0]                               issue_data,
  output logic                                                  retire_valid,
  output logic                                                  retire_complete,
  output mshr_pkg::bus_command_e                                retire_command,
  output logic [`MSHR_ADDR_W-1:0]                               retire_addr,
  output logic [`MSHR_DATA_W-1:0]                               retire_data,
  output logic                                                  retire_dirty
);

  import mshr_pkg::*;

  localparam int IDX_W = $clog2(`MSHR_DEPTH);

  // control state
  logic [`MSHR_DEPTH-1:0] entry_valid;
  logic [`MSHR_DEPTH-1:0] entry_complete;
  entry_state_e           entry_state [`MSHR_DEPTH];
  logic [IDX_W-1:0]       tail;

  // payload
  logic [`MSHR_ADDR_W-1:0] entry_addr [`MSHR_DEPTH];
  logic [`MSHR_DATA_W-1:0] entry_data [`MSHR_DEPTH];
  logic [`MSHR_DEPTH-1:0]  entry_dirty;
  bus_command_e            entry_command [`MSHR_DEPTH];
  logic [`MSHR_TAG_W-1:0]  entry_mem_tag [`MSHR_DEPTH];

  logic [IDX_W-1:0]       slot_index [`MSHR_MISS_PORTS];
  logic [`MSHR_DEPTH-1:0] tag_hit;
  logic                   slot_clash;

  always_comb begin
    alloc_ready = 1'b1;
    slot_clash = 1'b0;
    for (int k = 0; k < `MSHR_MISS_PORTS; k++) begin
      slot_index[k] = tail + IDX_W'(k);
      if (entry_valid[slot_index[k]]) begin
        alloc_ready = 1'b0;
        slot_clash = slot_clash | slot_we[k];
      end
    end
  end

  // completion tag lookup over all outstanding entries
  always_comb begin
    for (int i = 0; i < `MSHR_DEPTH; i++) begin
      tag_hit[i] = entry_valid[i] && (entry_state[i] == in_progress) &&
                   (mem2proc_tag != '0) && (mem2proc_tag == entry_mem_tag[i]);
    end
  end

  assign mshr_empty = ~(|entry_valid);

  assign issue_valid    = entry_valid[issue_index];
  assign issue_complete = entry_complete[issue_index];
  assign issue_command  = entry_command[issue_index];
  assign issue_addr     = entry_addr[issue_index];
  assign issue_data     = entry_data[issue_index];

  assign retire_valid    = entry_valid[retire_index];
  assign retire_complete = entry_complete[retire_index];
  assign retire_command  = entry_command[retire_index];
  assign retire_addr     = entry_addr[retire_index];
  assign retire_data     = entry_data[retire_index];
  assign retire_dirty    = entry_dirty[retire_index];

  always_ff @(posedge clock) begin
    if (reset) begin
      tail <= '0;
      entry_valid <= '0;
      entry_complete <= '0;
      for (int i = 0; i < `MSHR_DEPTH; i++) begin
        entry_state[i] <= waiting;
      end
    end else begin
      tail <= tail + IDX_W'(alloc_count);
      for (int k = 0; k < `MSHR_MISS_PORTS; k++) begin
        if (slot_we[k]) begin
          entry_valid[slot_index[k]] <= 1'b1;
          entry_complete[slot_index[k]] <= 1'b0;
          entry_state[slot_index[k]] <= waiting;
        end
      end
      if (issue_accept) begin
        entry_state[issue_index] <= in_progress;
        // a store is finished once memory takes it
        if (entry_command[issue_index] == bus_store) begin
          entry_complete[issue_index] <= 1'b1;
        end
      end
      for (int i = 0; i < `MSHR_DEPTH; i++) begin
        if (tag_hit[i]) begin
          entry_state[i] <= done;
          entry_complete[i] <= 1'b1;
        end
      end
      if (retire) begin
        entry_valid[retire_index] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int k = 0; k < `MSHR_MISS_PORTS; k++) begin
      if (slot_we[k]) begin
        entry_addr[slot_index[k]] <= slot_addr[k];
        entry_data[slot_index[k]] <= slot_data[k];
        entry_dirty[slot_index[k]] <= slot_dirty[k];
        entry_command[slot_index[k]] <= slot_command[k];
      end
    end
    if (issue_accept) begin
      entry_mem_tag[issue_index] <= issue_tag;
    end
    // load fill data arrives clean
    for (int i = 0; i < `MSHR_DEPTH; i++) begin
      if (tag_hit[i] && (entry_command[i] == bus_load)) begin
        entry_data[i] <= mem2proc_data;
        entry_dirty[i] <= 1'b0;
      end
    end
  end

  slot_overwrite: assert property (
    @(posedge clock) disable iff (reset) !slot_clash
  ) else $error("allocation into a valid entry");

endmodule

// File: src/mshr_top.sv
`timescale 1ns/1ps
`include "mshr_cfg.svh"

module mshr_top (
  input  logic                                                  clock,
  input  logic                                                  reset,
  input  logic [`MSHR_MISS_PORTS-1:0]                           miss_en,
  input  logic [`MSHR_MISS_PORTS-1:0][`MSHR_ADDR_W-1:0]         miss_addr,
  input  logic [`MSHR_MISS_PORTS-1:0][`MSHR_DATA_W-1:0]         miss_data,
  input  mshr_pkg::bus_command_e [`MSHR_MISS_PORTS-1:0]         miss_command,
  input  logic [`MSHR_MISS_PORTS-1:0]                           miss_dirty,
  input  logic                                                  stored_mem_wr,
  output logic                                                  alloc_ready,
  output logic                                                  mshr_empty,
  output logic                                                  mem_wr,
  output logic [`MSHR_ADDR_W-1:0]                               mem_addr,
  output logic [`MSHR_DATA_W-1:0]                               mem_data,
  output logic                                                  mem_dirty,
  output mshr_pkg::bus_command_e                                proc2mem_command,
  output logic [`MSHR_ADDR_W-1:0]                               proc2mem_addr,
  output logic [`MSHR_DATA_W-1:0]                               proc2mem_data,
  input  logic [`MSHR_TAG_W-1:0]                                mem2proc_response,
  input  logic [`MSHR_TAG_W-1:0]                                mem2proc_tag,
  input  logic [`MSHR_DATA_W-1:0]                               mem2proc_data
);

  import mshr_pkg::*;

  localparam int IDX_W = $clog2(`MSHR_DEPTH);
  localparam int CNT_W = $clog2(`MSHR_MISS_PORTS + 1);

  // intake to queue
  logic [`MSHR_MISS_PORTS-1:0]                   slot_we;
  logic [`MSHR_MISS_PORTS-1:0][`MSHR_ADDR_W-1:0] slot_addr;
  logic [`MSHR_MISS_PORTS-1:0][`MSHR_DATA_W-1:0] slot_data;
  bus_command_e [`MSHR_MISS_PORTS-1:0]           slot_command;
  logic [`MSHR_MISS_PORTS-1:0]                   slot_dirty;
  logic [CNT_W-1:0]                              alloc_count;

  // scheduler and queue
  logic                    issue_accept;
  logic [IDX_W-1:0]        issue_index;
  logic [`MSHR_TAG_W-1:0]  issue_tag;
  logic                    retire;
  logic [IDX_W-1:0]        retire_index;
  logic                    issue_valid;
  logic                    issue_complete;
  bus_command_e            issue_command;
  logic [`MSHR_ADDR_W-1:0] issue_addr;
  logic [`MSHR_DATA_W-1:0] issue_data;
  logic                    retire_valid;
  logic                    retire_complete;
  bus_command_e            retire_command;
  logic [`MSHR_ADDR_W-1:0] retire_addr;
  logic [`MSHR_DATA_W-1:0] retire_data;
  logic                    retire_dirty;

  miss_intake miss_intake_inst (
    .clock(clock), .reset(reset), .miss_en(miss_en), .miss_addr(miss_addr),
    .miss_data(miss_data), .miss_command(miss_command), .miss_dirty(miss_dirty),
    .alloc_ready(alloc_ready), .slot_we(slot_we), .slot_addr(slot_addr),
    .slot_data(slot_data), .slot_command(slot_command), .slot_dirty(slot_dirty),
    .alloc_count(alloc_count)
  );

  mshr_queue mshr_queue_inst (
    .clock(clock), .reset(reset), .alloc_count(alloc_count), .slot_we(slot_we),
    .slot_addr(slot_addr), .slot_data(slot_data), .slot_command(slot_command),
    .slot_dirty(slot_dirty), .issue_accept(issue_accept), .issue_index(issue_index),
    .issue_tag(issue_tag), .retire(retire), .retire_index(retire_index),
    .mem2proc_tag(mem2proc_tag), .mem2proc_data(mem2proc_data),
    .alloc_ready(alloc_ready), .mshr_empty(mshr_empty), .issue_valid(issue_valid),
    .issue_complete(issue_complete), .issue_command(issue_command),
    .issue_addr(issue_addr), .issue_data(issue_data), .retire_valid(retire_valid),
    .retire_complete(retire_complete), .retire_command(retire_command),
    .retire_addr(retire_addr), .retire_data(retire_data), .retire_dirty(retire_dirty)
  );

  mem_scheduler mem_scheduler_inst (
    .clock(clock), .reset(reset), .issue_valid(issue_valid),
    .issue_complete(issue_complete), .issue_command(issue_command),
    .issue_addr(issue_addr), .issue_data(issue_data), .retire_valid(retire_valid),
    .retire_complete(retire_complete), .retire_command(retire_command),
    .retire_addr(retire_addr), .retire_data(retire_data), .retire_dirty(retire_dirty),
    .mem2proc_response(mem2proc_response), .stored_mem_wr(stored_mem_wr),
    .proc2mem_command(proc2mem_command), .proc2mem_addr(proc2mem_addr),
    .proc2mem_data(proc2mem_data), .issue_accept(issue_accept),
    .issue_index(issue_index), .issue_tag(issue_tag), .retire(retire),
    .retire_index(retire_index), .mem_wr(mem_wr), .mem_addr(mem_addr),
    .mem_data(mem_data), .mem_dirty(mem_dirty)
  );

endmodule
